//--- bench/sat_flip_checker.sv
// ==========================================================
// bound protocol checks on the flip datapath
//   single-cycle flip strobe, fixed accept latency,
//   no clause or table strobe while busy
// ==========================================================
`timescale 1ns/1ps

module sat_flip_checker (
    input logic clk_i,
    input logic rst_i,
    input logic clause_valid_i,
    input logic ready_o,
    input logic flip_valid_o,
    input logic att_wr_en_i,
    input logic ct_wr_en_i,
    input logic var_wr_en_i
);

    logic accept;

    assign accept = clause_valid_i & ready_o;

    a_flip_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        flip_valid_o |=> !flip_valid_o)
        else $error("flip_valid_o stayed high for more than one cycle");

    // strobe rises at E6, so it is first sampled high one edge later
    a_flip_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        accept |=> (!flip_valid_o) [*sat_pkg::LATENCY] ##1 flip_valid_o)
        else $error("flip_valid_o missing or early after an accepted clause");

    a_flip_has_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        flip_valid_o |-> $past(accept, sat_pkg::LATENCY + 1))
        else $error("flip_valid_o without an accept LATENCY cycles before");

    a_no_strobe_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        !ready_o |-> !(clause_valid_i || att_wr_en_i || ct_wr_en_i || var_wr_en_i))
        else $error("clause or table write strobe while ready_o is low");

endmodule

bind sat_flip_datapath sat_flip_checker i_sat_flip_checker (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .clause_valid_i (clause_valid_i),
    .ready_o        (ready_o),
    .flip_valid_o   (flip_valid_o),
    .att_wr_en_i    (att_wr_en_i),
    .ct_wr_en_i     (ct_wr_en_i),
    .var_wr_en_i    (var_wr_en_i)
);

//--- bench/sat_flip_tb.sv
// ==========================================================
// testbench for the WalkSAT flip datapath
//   random 3-SAT formula, ATT / CT / assignment loading
//   reference break counts, xorshift noise and flip choice
//   latency and flip report comparison, watchdog
// ==========================================================
`timescale 1ns/1ps

module sat_flip_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_CL       = 36;   // clauses in the formula
    localparam int NUM_STEPS    = 300;  // flips checked
    localparam int LOAD_CYC     = 8 + sat_pkg::NUM_LITS + sat_pkg::NUM_ROWS
                                  + (NUM_STEPS + 1) * sat_pkg::NUM_VARS;  // worst case reloads
    localparam int WATCHDOG_CYC = NUM_STEPS * (sat_pkg::LATENCY + 4) + LOAD_CYC;

    logic                           clk_i;
    logic                           rst_i;
    logic                           att_wr_en_i;
    logic [sat_pkg::LIT_W-1:0]      att_wr_addr_i;
    sat_pkg::att_entry_t            att_wr_data_i;
    logic                           ct_wr_en_i;
    logic [sat_pkg::ROW_ADDR_W-1:0] ct_wr_addr_i;
    sat_pkg::ct_row_t               ct_wr_data_i;
    logic                           var_wr_en_i;
    logic [sat_pkg::VAR_ADDR_W-1:0] var_wr_addr_i;
    logic                           var_wr_data_i;
    logic                           clause_valid_i;
    sat_pkg::clause_t               clause_i;
    logic                           ready_o;
    logic                           flip_valid_o;
    sat_pkg::flip_t                 flip_o;

    sat_pkg::clause_t  formula [NUM_CL];
    sat_pkg::var_vec_t model_assign;  // what the DUT store should hold
    logic [31:0]       model_prng;
    sat_pkg::flip_t    want_q [$];
    string             kind_q [$];
    int                n_checked = 0;
    int                n_free    = 0;
    int                n_noisy   = 0;
    int                n_greedy  = 0;

    sat_flip_datapath i_sat_flip_datapath (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(string test, logic [31:0] want, logic [31:0] got);
        assert (want === got) else
            stop_with_failure($sformatf("[ERROR] %s expected %h actual %h", test, want, got));
    endtask

    function automatic logic [31:0] xorshift_step(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // literal is false when the variable equals its negation bit
    function automatic logic lit_false(sat_pkg::literal_t l);
        return model_assign[l.addr] == l.neg;
    endfunction

    // clauses holding the complement of l that rely on it alone
    function automatic int count_breaks(sat_pkg::literal_t l);
        int cnt;
        cnt = 0;
        for (int i = 0; i < NUM_CL; i++) begin
            for (int j = 0; j < sat_pkg::NSAT; j++) begin
                if (formula[i].lit[j].addr == l.addr && formula[i].lit[j].neg != l.neg &&
                    lit_false(formula[i].lit[(j + 1) % 3]) &&
                    lit_false(formula[i].lit[(j + 2) % 3])) begin
                    cnt++;
                end
            end
        end
        return cnt;
    endfunction

    function automatic sat_pkg::flip_t predict_flip(sat_pkg::clause_t c, logic [31:0] draw,
                                                    output string kind);
        int             b [sat_pkg::NSAT];
        int             pick;
        sat_pkg::flip_t f;
        pick    = -1;
        f.noisy = 1'b0;
        for (int k = 0; k < sat_pkg::NSAT; k++) b[k] = count_breaks(c.lit[k]);
        for (int k = sat_pkg::NSAT - 1; k >= 0; k--) begin
            if (b[k] == 0) pick = k;  // lowest zero wins
        end
        if (pick >= 0) begin
            kind = "freebie";
        end else if (draw[7:0] < sat_pkg::NOISE_THRESH) begin
            pick    = draw[15:8] % 3;
            f.noisy = 1'b1;
            kind    = "noise";
        end else begin
            pick = 0;
            for (int k = 1; k < sat_pkg::NSAT; k++) begin
                if (b[k] < b[pick]) pick = k;
            end
            kind = "greedy";
        end
        f.var_addr = c.lit[pick].addr;
        f.value    = ~c.lit[pick].neg;  // chosen literal becomes true
        f.cand     = sat_pkg::CAND_W'(pick);
        f.breaks   = sat_pkg::BREAK_W'(b[pick]);
        return f;
    endfunction

    // three distinct variables, no literal used more than MC times
    task automatic build_formula();
        int occ [sat_pkg::NUM_LITS];
        int v [sat_pkg::NSAT];
        int ng [sat_pkg::NSAT];
        int lc [sat_pkg::NSAT];
        int tries;
        foreach (occ[c]) occ[c] = 0;
        for (int i = 0; i < NUM_CL; i++) begin
            tries = 0;
            do begin
                tries++;
                assert (tries < 1000) else
                    stop_with_failure("random formula generation ran out of tries");
                for (int k = 0; k < sat_pkg::NSAT; k++) begin
                    v[k]  = $urandom % sat_pkg::NUM_VARS;
                    ng[k] = $urandom % 2;
                    lc[k] = ng[k] * sat_pkg::NUM_VARS + v[k];  // {neg, addr}
                end
            end while (v[0] == v[1] || v[0] == v[2] || v[1] == v[2] ||
                       occ[lc[0]] >= sat_pkg::MC || occ[lc[1]] >= sat_pkg::MC ||
                       occ[lc[2]] >= sat_pkg::MC);
            for (int k = 0; k < sat_pkg::NSAT; k++) begin
                formula[i].lit[k].neg  = 1'(ng[k]);
                formula[i].lit[k].addr = sat_pkg::VAR_ADDR_W'(v[k]);
                occ[lc[k]]++;
            end
        end
    endtask

    // literal c owns CT row c ^ 11, slot order follows clause order
    task automatic load_tables();
        sat_pkg::att_entry_t att_img [sat_pkg::NUM_LITS];
        sat_pkg::ct_row_t    ct_img [sat_pkg::NUM_ROWS];
        int                  fill [sat_pkg::NUM_LITS];
        int                  code;
        int                  row;
        for (int c = 0; c < sat_pkg::NUM_LITS; c++) begin
            att_img[c].row  = sat_pkg::ROW_ADDR_W'(c ^ 11);
            att_img[c].mask = '0;
            ct_img[c]       = '0;
            fill[c]         = 0;
        end
        for (int i = 0; i < NUM_CL; i++) begin
            for (int j = 0; j < sat_pkg::NSAT; j++) begin
                code = {formula[i].lit[j].neg, formula[i].lit[j].addr};
                row  = att_img[code].row;
                ct_img[row].lits[fill[code]][0] = formula[i].lit[(j + 1) % 3];
                ct_img[row].lits[fill[code]][1] = formula[i].lit[(j + 2) % 3];
                att_img[code].mask[fill[code]]  = 1'b1;
                fill[code]++;
            end
        end
        for (int c = 0; c < sat_pkg::NUM_LITS; c++) begin
            att_wr_en_i   = 1'b1;
            att_wr_addr_i = sat_pkg::LIT_W'(c);
            att_wr_data_i = att_img[c];
            @(posedge clk_i);
            #1;
        end
        att_wr_en_i = 1'b0;
        for (int r = 0; r < sat_pkg::NUM_ROWS; r++) begin
            ct_wr_en_i   = 1'b1;
            ct_wr_addr_i = sat_pkg::ROW_ADDR_W'(r);
            ct_wr_data_i = ct_img[r];
            @(posedge clk_i);
            #1;
        end
        ct_wr_en_i = 1'b0;
    endtask

    task automatic randomize_assignment();
        for (int v = 0; v < sat_pkg::NUM_VARS; v++) begin
            var_wr_en_i     = 1'b1;
            var_wr_addr_i   = sat_pkg::VAR_ADDR_W'(v);
            var_wr_data_i   = 1'($urandom % 2);
            model_assign[v] = var_wr_data_i;
            @(posedge clk_i);
            #1;
        end
        var_wr_en_i = 1'b0;
    endtask

    function automatic bit choose_unsat_clause(output sat_pkg::clause_t c);
        int idx [$];
        c = '0;
        for (int i = 0; i < NUM_CL; i++) begin
            if (lit_false(formula[i].lit[0]) && lit_false(formula[i].lit[1]) &&
                lit_false(formula[i].lit[2])) idx.push_back(i);
        end
        if (idx.size() == 0) return 1'b0;  // formula satisfied
        c = formula[idx[$urandom % idx.size()]];
        return 1'b1;
    endfunction

    // predict, queue the result, hand the clause over, wait for ready
    task automatic send_clause(sat_pkg::clause_t c);
        sat_pkg::flip_t want;
        string          kind;
        assert (ready_o) else stop_with_failure("ready_o low when a clause was due");
        model_prng = xorshift_step(model_prng);  // every decision draws once
        want       = predict_flip(c, model_prng, kind);
        model_assign[want.var_addr] = want.value;
        if (kind == "freebie") n_free++;
        else if (kind == "noise") n_noisy++;
        else n_greedy++;
        want_q.push_back(want);
        kind_q.push_back(kind);
        clause_i       = c;
        clause_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        clause_valid_i = 1'b0;
        do begin
            @(posedge clk_i);
            #1;
        end while (!ready_o);
    endtask

    initial begin : stimulus
        sat_pkg::clause_t c;
        void'($urandom(32'h44db6173));
        rst_i          = 1'b1;
        att_wr_en_i    = 1'b0;
        att_wr_addr_i  = '0;
        att_wr_data_i  = '0;
        ct_wr_en_i     = 1'b0;
        ct_wr_addr_i   = '0;
        ct_wr_data_i   = '0;
        var_wr_en_i    = 1'b0;
        var_wr_addr_i  = '0;
        var_wr_data_i  = 1'b0;
        clause_valid_i = 1'b0;
        clause_i       = '0;
        model_assign   = '0;                  // store clears on reset
        model_prng     = sat_pkg::PRNG_SEED;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        repeat (4) begin                      // idle, nothing may flip
            @(posedge clk_i);
            #1;
            assert (ready_o && !flip_valid_o) else
                stop_with_failure("ready_o low or flip_valid_o high while idle after reset");
        end
        build_formula();
        load_tables();
        randomize_assignment();
        for (int n = 0; n < NUM_STEPS; n++) begin
            while (!choose_unsat_clause(c)) randomize_assignment();  // restart when solved
            send_clause(c);
        end
        wait (n_checked == NUM_STEPS);
        assert (n_free > 0 && n_noisy > 0 && n_greedy > 0) else
            stop_with_failure("freebie, noise or greedy flips were never exercised");
        $display("Testbench passed");
        $finish;
    end

    // accept seen mid-cycle, then E1..E6 counted edge by edge
    initial begin : compare
        sat_pkg::flip_t want;
        string          kind;
        forever begin
            @(negedge clk_i);
            if (!rst_i && clause_valid_i && ready_o) begin
                assert (want_q.size() > 0) else
                    stop_with_failure("clause accepted with no predicted flip queued");
                want = want_q.pop_front();
                kind = kind_q.pop_front();
                @(posedge clk_i);             // E0
                for (int k = 1; k < sat_pkg::LATENCY; k++) begin
                    @(posedge clk_i);
                    #1;
                    assert (!flip_valid_o && !ready_o) else
                        stop_with_failure($sformatf("flip or ready too early, %0d cycles", k));
                end
                @(posedge clk_i);             // E6
                #1;
                check_value($sformatf("flip_valid_o %s flip %0d", kind, n_checked),
                            32'd1, 32'(flip_valid_o));
                check_value($sformatf("ready_o %s flip %0d", kind, n_checked),
                            32'd1, 32'(ready_o));
                check_value($sformatf("flip_o %s flip %0d", kind, n_checked),
                            32'(want), 32'(flip_o));
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYC * CLK_PERIOD);
        stop_with_failure("watchdog expired before all flips were checked");
    end

endmodule

//--- flist.f
hdl/sat_pkg.sv
hdl/sat_table_ram.sv
hdl/break_evaluator.sv
hdl/flip_sequencer.sv
hdl/variable_flip_unit.sv
hdl/sat_flip_datapath.sv
bench/sat_flip_checker.sv
bench/sat_flip_tb.sv

//--- hdl/break_evaluator.sv
// ==========================================================
// break count for one candidate per cycle
//   mask delay to meet the CT row
//   per-slot broken test against the assignment
//   registered population count
// ==========================================================
`timescale 1ns/1ps

module break_evaluator (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [sat_pkg::MC-1:0]       mask_i,    // from ATT, one cycle early
    input  sat_pkg::ct_row_t             row_i,     // from CT
    input  sat_pkg::var_vec_t            assign_i,  // current assignment
    output logic [sat_pkg::BREAK_W-1:0]  break_o
);

    logic [sat_pkg::MC-1:0]      mask_q;    // mask aligned with row_i
    logic [sat_pkg::MC-1:0]      slot_brk;  // slot would break on the flip
    logic [sat_pkg::BREAK_W-1:0] brk_sum;

    // ATT data leads the CT data by the CT read cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask_q <= '0;
        end else begin
            mask_q <= mask_i;
        end
    end

    // the flipped literal goes false, so the clause breaks
    // only if every remaining literal is false already
    always_comb begin
        for (int s = 0; s < sat_pkg::MC; s++) begin
            slot_brk[s] = mask_q[s];  // empty slots never count
            for (int j = 0; j < sat_pkg::NSAT - 1; j++) begin
                // false when value equals the negation bit
                slot_brk[s] &= (assign_i[row_i.lits[s][j].addr] == row_i.lits[s][j].neg);
            end
        end
    end

    always_comb begin
        brk_sum = '0;
        for (int s = 0; s < sat_pkg::MC; s++) begin
            brk_sum = brk_sum + sat_pkg::BREAK_W'(slot_brk[s]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            break_o <= '0;
        end else begin
            break_o <= brk_sum;  // valid the cycle after E(k+3)
        end
    end

endmodule

//--- hdl/flip_sequencer.sv
// ==========================================================
// step sequencer for one flip
//   clause register and accept handshake
//   negated literal lookups, one per cycle
//   candidate tag delay line, decide strobe
// ==========================================================
`timescale 1ns/1ps

module flip_sequencer (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        clause_valid_i,
    input  sat_pkg::clause_t            clause_i,
    output logic                        ready_o,
    output logic [sat_pkg::LIT_W-1:0]   lookup_addr_o,  // ATT read address
    output logic                        break_valid_o,
    output logic [sat_pkg::CAND_W-1:0]  break_index_o,
    output logic                        decide_o,
    output sat_pkg::clause_t            cand_lit_o      // held clause for the flip unit
);

    logic [$clog2(sat_pkg::LATENCY+1)-1:0] cnt_q;  // 0 idle, 1..LATENCY busy
    sat_pkg::clause_t                      clause_q;
    logic                                  accept;
    logic                                  issue_vld;
    logic [sat_pkg::CAND_W-1:0]            issue_idx;
    sat_pkg::literal_t                     issue_lit;

    // tag delay matches ATT read, CT read and break register
    logic [2:0]                 tag_vld_q;
    logic [sat_pkg::CAND_W-1:0] tag_idx_q [3];

    assign ready_o = (cnt_q == '0);
    assign accept  = clause_valid_i & ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (accept) begin
            cnt_q <= 1'b1;  // E0
        end else if (cnt_q == sat_pkg::LATENCY) begin
            cnt_q <= '0;  // ready again at E6
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // clause register, only written on accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            clause_q <= clause_i;
        end
    end

    // candidate k is looked up in busy cycle k+1
    assign issue_vld = (cnt_q != '0) && (cnt_q <= sat_pkg::NSAT);
    assign issue_idx = issue_vld ? sat_pkg::CAND_W'(cnt_q - 1'b1) : '0;
    assign issue_lit = clause_q.lit[issue_idx];

    // flip the negation bit, the ATT is indexed by the negated literal
    assign lookup_addr_o = {~issue_lit.neg, issue_lit.addr};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tag_vld_q <= '0;
        end else begin
            tag_vld_q <= {tag_vld_q[1:0], issue_vld};
        end
    end

    always_ff @(posedge clk_i) begin
        tag_idx_q[0] <= issue_idx;
        tag_idx_q[1] <= tag_idx_q[0];
        tag_idx_q[2] <= tag_idx_q[1];
    end

    assign break_valid_o = tag_vld_q[2];  // busy cycles 4..6
    assign break_index_o = tag_idx_q[2];
    assign decide_o      = (cnt_q == sat_pkg::LATENCY);  // last count arrives here too
    assign cand_lit_o    = clause_q;

endmodule

//--- hdl/sat_flip_datapath.sv
// ==========================================================
// top of the flip step datapath
//   sequencer, address translation table, clause table,
//   break evaluator and flip unit
//   table load ports are plain strobes
// ==========================================================
`timescale 1ns/1ps

module sat_flip_datapath (
    input  logic                           clk_i,
    input  logic                           rst_i,
    // address translation table load
    input  logic                           att_wr_en_i,
    input  logic [sat_pkg::LIT_W-1:0]      att_wr_addr_i,
    input  sat_pkg::att_entry_t            att_wr_data_i,
    // clause table load
    input  logic                           ct_wr_en_i,
    input  logic [sat_pkg::ROW_ADDR_W-1:0] ct_wr_addr_i,
    input  sat_pkg::ct_row_t               ct_wr_data_i,
    // assignment load
    input  logic                           var_wr_en_i,
    input  logic [sat_pkg::VAR_ADDR_W-1:0] var_wr_addr_i,
    input  logic                           var_wr_data_i,
    // unsat clause in
    input  logic                           clause_valid_i,
    input  sat_pkg::clause_t               clause_i,
    output logic                           ready_o,
    // flip out
    output logic                           flip_valid_o,
    output sat_pkg::flip_t                 flip_o
);

    logic [sat_pkg::LIT_W-1:0]   seq_lookup_addr;  // negated literal
    logic                        seq_break_valid;
    logic [sat_pkg::CAND_W-1:0]  seq_break_index;
    logic                        seq_decide;
    sat_pkg::clause_t            seq_clause;
    sat_pkg::att_entry_t         att_entry;        // row pointer + mask
    sat_pkg::ct_row_t            ct_row;
    logic [sat_pkg::BREAK_W-1:0] ev_break;
    sat_pkg::var_vec_t           fu_assign;

    flip_sequencer i_flip_sequencer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .clause_valid_i (clause_valid_i),
        .clause_i       (clause_i),
        .ready_o        (ready_o),
        .lookup_addr_o  (seq_lookup_addr),
        .break_valid_o  (seq_break_valid),
        .break_index_o  (seq_break_index),
        .decide_o       (seq_decide),
        .cand_lit_o     (seq_clause)
    );

    // literal -> CT row and valid slots
    sat_table_ram #(
        .entry_t (sat_pkg::att_entry_t),
        .DEPTH   (sat_pkg::NUM_LITS)
    ) i_att (
        .clk_i     (clk_i),
        .wr_en_i   (att_wr_en_i),
        .wr_addr_i (att_wr_addr_i),
        .wr_data_i (att_wr_data_i),
        .rd_addr_i (seq_lookup_addr),
        .rd_data_o (att_entry)
    );

    // row -> other literals of each clause
    sat_table_ram #(
        .entry_t (sat_pkg::ct_row_t),
        .DEPTH   (sat_pkg::NUM_ROWS)
    ) i_ct (
        .clk_i     (clk_i),
        .wr_en_i   (ct_wr_en_i),
        .wr_addr_i (ct_wr_addr_i),
        .wr_data_i (ct_wr_data_i),
        .rd_addr_i (att_entry.row),  // chained straight off the ATT register
        .rd_data_o (ct_row)
    );

    break_evaluator i_break_evaluator (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .mask_i   (att_entry.mask),
        .row_i    (ct_row),
        .assign_i (fu_assign),
        .break_o  (ev_break)
    );

    variable_flip_unit i_variable_flip_unit (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .var_wr_en_i   (var_wr_en_i),
        .var_wr_addr_i (var_wr_addr_i),
        .var_wr_data_i (var_wr_data_i),
        .break_valid_i (seq_break_valid),
        .break_index_i (seq_break_index),
        .break_i       (ev_break),
        .decide_i      (seq_decide),
        .clause_i      (seq_clause),
        .assign_o      (fu_assign),
        .flip_valid_o  (flip_valid_o),
        .flip_o        (flip_o)
    );

endmodule

//--- hdl/sat_pkg.sv
// ==========================================================
// shared sizes, constants and packed types for the
// single-step WalkSAT flip datapath
//   literal / clause formats, ATT entry, CT row,
//   assignment vector and flip report
// ==========================================================
package sat_pkg;

    // problem sizes
    localparam int NSAT       = 3;               // literals per clause
    localparam int VAR_ADDR_W = 4;
    localparam int NUM_VARS   = 16;              // 2**VAR_ADDR_W
    localparam int LIT_W      = VAR_ADDR_W + 1;  // negation bit on top
    localparam int NUM_LITS   = 32;              // ATT depth, one entry per literal
    localparam int MC         = 4;               // max clauses holding one literal
    localparam int ROW_ADDR_W = 5;
    localparam int NUM_ROWS   = 32;              // CT depth
    localparam int BREAK_W    = 3;               // holds 0..MC
    localparam int CAND_W     = 2;               // candidate index 0..NSAT-1

    // flip selection
    localparam logic [31:0] PRNG_SEED    = 32'h1f2e3d4c;  // must not be zero
    localparam logic [7:0]  NOISE_THRESH = 8'd77;         // 77/256, roughly 0.3

    // accept edge to flip_valid_o edge
    localparam int LATENCY = 6;

    // neg = 1 means the complemented variable
    typedef struct packed {
        logic                  neg;
        logic [VAR_ADDR_W-1:0] addr;
    } literal_t;

    typedef struct packed {
        literal_t [NSAT-1:0] lit;  // lit[0] sits in the low bits
    } clause_t;

    // address translation entry, points at a CT row
    typedef struct packed {
        logic [ROW_ADDR_W-1:0] row;
        logic [MC-1:0]         mask;  // one bit per valid CT slot
    } att_entry_t;

    // every slot keeps the other NSAT-1 literals of one clause
    typedef struct packed {
        literal_t [MC-1:0][NSAT-2:0] lits;
    } ct_row_t;

    typedef logic [NUM_VARS-1:0] var_vec_t;

    typedef struct packed {
        logic [VAR_ADDR_W-1:0] var_addr;  // flipped variable
        logic                  value;     // its new value
        logic [CAND_W-1:0]     cand;      // which literal of the clause
        logic [BREAK_W-1:0]    breaks;    // break count of that candidate
        logic                  noisy;     // random pick, not greedy
    } flip_t;

endpackage

//--- hdl/sat_table_ram.sv
// ==========================================================
// generic table, one write port and a registered read
// used for the address translation and clause tables
// ==========================================================
`timescale 1ns/1ps

module sat_table_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 32
) (
    input  logic                     clk_i,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  entry_t                   wr_data_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output entry_t                   rd_data_o
);

    entry_t mem [DEPTH];  // contents come from the load port only

    // write and read on the same edge, read returns the old word
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];  // one cycle address to data
    end

endmodule

//--- hdl/variable_flip_unit.sv
// ==========================================================
// assignment store and flip decision
//   variable table with load port and flip write
//   xorshift32 noise source
//   freebie / noise / greedy candidate choice
//   registered flip report
// ==========================================================
`timescale 1ns/1ps

module variable_flip_unit (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          var_wr_en_i,
    input  logic [sat_pkg::VAR_ADDR_W-1:0] var_wr_addr_i,
    input  logic                          var_wr_data_i,
    input  logic                          break_valid_i,
    input  logic [sat_pkg::CAND_W-1:0]    break_index_i,
    input  logic [sat_pkg::BREAK_W-1:0]   break_i,
    input  logic                          decide_i,
    input  sat_pkg::clause_t              clause_i,
    output sat_pkg::var_vec_t             assign_o,
    output logic                          flip_valid_o,
    output sat_pkg::flip_t                flip_o
);

    sat_pkg::var_vec_t           assign_q;
    logic [31:0]                 prng_q;
    logic [31:0]                 prng_nxt;
    logic [sat_pkg::BREAK_W-1:0] brk0_q;  // candidate 0, captured early
    logic [sat_pkg::BREAK_W-1:0] brk1_q;
    logic [sat_pkg::BREAK_W-1:0] cand_brk [sat_pkg::NSAT];

    logic                        free_hit;
    logic [sat_pkg::CAND_W-1:0]  free_idx;
    logic [sat_pkg::CAND_W-1:0]  min_idx;
    logic [sat_pkg::CAND_W-1:0]  rnd_idx;
    logic                        noisy;
    logic [sat_pkg::CAND_W-1:0]  pick;
    sat_pkg::literal_t           pick_lit;
    logic                        new_val;

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign prng_nxt = xorshift32(prng_q);  // draw used by this decision
    assign assign_o = assign_q;

    // candidate 2 is still on break_i when decide is high
    always_comb begin
        cand_brk[0] = brk0_q;
        cand_brk[1] = brk1_q;
        cand_brk[2] = break_i;
    end

    always_comb begin
        free_hit = 1'b0;
        free_idx = '0;
        // scan downwards so the lowest zero wins
        for (int k = sat_pkg::NSAT - 1; k >= 0; k--) begin
            if (cand_brk[k] == '0) begin
                free_hit = 1'b1;
                free_idx = sat_pkg::CAND_W'(k);
            end
        end
        min_idx = '0;
        for (int k = 1; k < sat_pkg::NSAT; k++) begin
            if (cand_brk[k] < cand_brk[min_idx]) begin  // strict, ties keep lower
                min_idx = sat_pkg::CAND_W'(k);
            end
        end
        rnd_idx = sat_pkg::CAND_W'(prng_nxt[15:8] % 8'd3);
        noisy   = ~free_hit & (prng_nxt[7:0] < sat_pkg::NOISE_THRESH);
        if (free_hit) begin
            pick = free_idx;
        end else if (noisy) begin
            pick = rnd_idx;
        end else begin
            pick = min_idx;
        end
        pick_lit = clause_i.lit[pick];
        new_val  = ~pick_lit.neg;  // makes the chosen literal true
    end

    // store, PRNG and report strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            assign_q     <= '0;
            prng_q       <= sat_pkg::PRNG_SEED;
            flip_valid_o <= 1'b0;
        end else begin
            flip_valid_o <= decide_i;  // one cycle, E6
            if (decide_i) begin
                assign_q[pick_lit.addr] <= new_val;
                prng_q                  <= prng_nxt;  // freebie steps it as well
            end else if (var_wr_en_i) begin
                assign_q[var_wr_addr_i] <= var_wr_data_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (break_valid_i && (break_index_i == 2'd0)) begin
            brk0_q <= break_i;
        end
        if (break_valid_i && (break_index_i == 2'd1)) begin
            brk1_q <= break_i;
        end
        if (decide_i) begin
            flip_o.var_addr <= pick_lit.addr;
            flip_o.value    <= new_val;
            flip_o.cand     <= pick;
            flip_o.breaks   <= cand_brk[pick];
            flip_o.noisy    <= noisy;
        end
    end

endmodule
